// File: hw/rv_bus_pkg.sv
package rv_bus_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    // Decode to execute
    typedef struct packed {
        logic [31:0] pc;
        inst_kind_e  kind;
        alu_op_e     alu_op;
        br_op_e      br_op;
        mem_size_e   mem_size;
        logic        load_unsigned;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        rd_we;
    } dec_bundle_t;

    // One record per retired instruction
    typedef struct packed {
        logic [31:0] pc;
        inst_kind_e  kind;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [31:0] mem_addr;
        mem_size_e   mem_size;
        logic [31:0] store_data;
    } retire_t;

endpackage

// File: hw/rv_core_slice.sv
`timescale 1ns/1ns

module rv_core_slice #(
    parameter int gpr_count = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  rv_bus_pkg::fetch_t  fetch,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    output rv_bus_pkg::retire_t retire,
    output logic                retire_valid
);

    import rv_bus_pkg::*;

    dec_bundle_t dec;
    logic        dec_valid;
    logic        exu_ready;
    logic [4:0]  rs1_addr, rs2_addr, wr_addr;
    logic [31:0] rs1_data, rs2_data, wr_data;
    logic        wr_en;

    rv_idu #(.gpr_count(gpr_count)) u_idu (
        .clk         (clk),
        .rst         (rst),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .exu_ready   (exu_ready),
        .fetch_ready (fetch_ready),
        .dec         (dec),
        .dec_valid   (dec_valid)
    );

    rv_exu u_exu (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec),
        .dec_valid    (dec_valid),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .exu_ready    (exu_ready),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    rv_gpr #(.gpr_count(gpr_count)) u_gpr (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// File: hw/rv_exu.sv
`timescale 1ns/1ns

module rv_exu (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_bus_pkg::dec_bundle_t dec,
    input  logic                    dec_valid,
    input  logic [31:0]             rs1_data,
    input  logic [31:0]             rs2_data,
    output logic                    exu_ready,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    output logic                    wr_en,
    output logic [4:0]              wr_addr,
    output logic [31:0]             wr_data,
    output rv_bus_pkg::retire_t     retire,
    output logic                    retire_valid
);

    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    typedef enum logic {IDLE, SHIFT} exu_state_e;

    exu_state_e  state;
    logic [31:0] op_a, op_b, alu_res, addr_sum, pc4;
    logic        taken, is_shift;
    logic [4:0]  sh_cnt;
    alu_op_e     sh_op;
    retire_t     ret_now;
    retire_t     hold;  // Shift in progress, result field is the shifter

    assign rs1_addr  = dec.rs1;
    assign rs2_addr  = dec.rs2;
    assign exu_ready = (state == IDLE);

    assign op_a     = dec.src1_is_pc ? dec.pc : rs1_data;
    assign op_b     = dec.src2_is_imm ? dec.imm : rs2_data;
    assign addr_sum = op_a + dec.imm;
    assign pc4      = dec.pc + 32'd4;
    assign is_shift = (dec.kind == K_ALU) && (dec.alu_op inside {SLL, SRL, SRA});

    // ################################################
    // ALU and branch compare
    // ################################################
    always_comb begin
        case (dec.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLT:     alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_res = {31'b0, op_a < op_b};
            AND:     alu_res = op_a & op_b;
            OR:      alu_res = op_a | op_b;
            XOR:     alu_res = op_a ^ op_b;
            default: alu_res = op_b;  // PASS_B, shifts go serial
        endcase
    end

    always_comb begin
        case (dec.br_op)
            BEQ:     taken = (rs1_data == rs2_data);
            BNE:     taken = (rs1_data != rs2_data);
            BLT:     taken = $signed(rs1_data) < $signed(rs2_data);
            BGE:     taken = $signed(rs1_data) >= $signed(rs2_data);
            BLTU:    taken = rs1_data < rs2_data;
            BGEU:    taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ret_now          = '0;
        ret_now.pc       = dec.pc;
        ret_now.kind     = dec.kind;
        ret_now.rd       = dec.rd;
        ret_now.rd_we    = dec.rd_we;
        ret_now.next_pc  = pc4;
        ret_now.mem_size = dec.mem_size;
        case (dec.kind)
            K_ALU:    ret_now.result = alu_res;
            K_BRANCH: if (taken) ret_now.next_pc = dec.pc + dec.imm;
            K_JUMP: begin
                ret_now.result  = pc4;                     // Link
                ret_now.next_pc = {addr_sum[31:1], 1'b0};
            end
            K_LOAD:   ret_now.mem_addr = addr_sum;
            K_STORE: begin
                ret_now.mem_addr   = addr_sum;
                ret_now.store_data = rs2_data;
            end
            default: ;  // System, ebreak, illegal fall through to pc+4
        endcase
    end

    // ################################################
    // Control
    // ################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            retire_valid <= 1'b0;
            sh_cnt       <= '0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                IDLE: if (dec_valid) begin
                    if (is_shift) begin
                        state  <= SHIFT;
                        sh_cnt <= op_b[4:0];
                    end else begin
                        retire_valid <= 1'b1;
                    end
                end
                SHIFT: if (sh_cnt == 5'd0) begin
                    state        <= IDLE;
                    retire_valid <= 1'b1;
                end else begin
                    sh_cnt <= sh_cnt - 5'd1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && dec_valid) begin
            retire      <= ret_now;
            hold        <= ret_now;
            hold.result <= op_a;
            sh_op       <= dec.alu_op;
        end else if (state == SHIFT) begin
            if (sh_cnt == 5'd0)
                retire <= hold;
            else begin
                case (sh_op)
                    SLL:     hold.result <= hold.result << 1;
                    SRL:     hold.result <= hold.result >> 1;
                    default: hold.result <= {hold.result[31], hold.result[31:1]};
                endcase
            end
        end
    end

    assign wr_en   = retire_valid & retire.rd_we;
    assign wr_addr = retire.rd;
    assign wr_data = retire.result;

endmodule

// File: hw/rv_gpr.sv
`timescale 1ns/1ns

module rv_gpr #(
    parameter int gpr_count = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [gpr_count];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gpr_count; i++) regs[i] <= '0;
        end else if (wr_en && wr_addr != 5'd0 && wr_addr < gpr_count) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // No bypass, a same-cycle read sees the old value
    assign rs1_data = (rs1_addr != 5'd0 && rs1_addr < gpr_count) ? regs[rs1_addr] : '0;
    assign rs2_data = (rs2_addr != 5'd0 && rs2_addr < gpr_count) ? regs[rs2_addr] : '0;

endmodule

// File: hw/rv_idu.sv
`timescale 1ns/1ns

module rv_idu #(
    parameter int gpr_count = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_bus_pkg::fetch_t      fetch,
    input  logic                    fetch_valid,
    input  logic                    exu_ready,
    output logic                    fetch_ready,
    output rv_bus_pkg::dec_bundle_t dec,
    output logic                    dec_valid
);

    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    typedef enum logic {IDLE, BUSY} idu_state_e;

    idu_state_e  state;
    logic [31:0] pc_r;
    logic [31:0] inst_r;
    dec_bundle_t nxt;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        use_rs1, use_rs2, use_rd;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? SUB : ADD;
            F3_SLL:     return SLL;
            F3_SLT:     return SLT;
            F3_SLTU:    return SLTU;
            F3_XOR:     return XOR;
            F3_SRL_SRA: return alt ? SRA : SRL;
            F3_OR:      return OR;
            default:    return AND;
        endcase
    endfunction

    assign fetch_ready = (state == IDLE);

    // ################################################
    // Field extraction
    // ################################################
    assign opcode  = opcode_e'(inst_r[6:0]);
    assign funct3  = inst_r[14:12];
    assign funct7  = inst_r[31:25];
    assign funct12 = inst_r[31:20];
    assign rs1     = inst_r[19:15];
    assign rs2     = inst_r[24:20];
    assign rd      = inst_r[11:7];

    assign imm_i = {{20{inst_r[31]}}, inst_r[31:20]};
    assign imm_s = {{20{inst_r[31]}}, inst_r[31:25], inst_r[11:7]};
    assign imm_b = {{20{inst_r[31]}}, inst_r[7], inst_r[30:25], inst_r[11:8], 1'b0};
    assign imm_u = {inst_r[31:12], 12'b0};
    assign imm_j = {{12{inst_r[31]}}, inst_r[19:12], inst_r[20], inst_r[30:21], 1'b0};

    always_comb begin
        nxt               = '0;
        nxt.pc            = pc_r;
        nxt.rs1           = rs1;
        nxt.rs2           = rs2;
        nxt.rd            = rd;
        nxt.kind          = K_ILLEGAL;  // Until a case below proves otherwise
        nxt.alu_op        = ADD;
        nxt.br_op         = br_op_e'(funct3);
        nxt.mem_size      = mem_size_e'(funct3[1:0]);
        nxt.load_unsigned = funct3[2];
        use_rs1           = 1'b0;
        use_rs2           = 1'b0;
        use_rd            = 1'b0;
        case (opcode)
            OP: begin
                if (funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)))
                    nxt.kind = K_ALU;
                nxt.alu_op = alu_from_f3(funct3, funct7[5]);
                nxt.rd_we  = 1'b1;
                {use_rs1, use_rs2, use_rd} = 3'b111;
            end
            OP_IMM: begin
                if ((funct3 != F3_SLL && funct3 != F3_SRL_SRA) || funct7 == F7_BASE ||
                    (funct3 == F3_SRL_SRA && funct7 == F7_ALT))
                    nxt.kind = K_ALU;
                nxt.alu_op      = alu_from_f3(funct3, funct3 == F3_SRL_SRA && funct7[5]);
                nxt.imm         = imm_i;
                nxt.src2_is_imm = 1'b1;
                nxt.rd_we       = 1'b1;
                {use_rs1, use_rd} = 2'b11;
            end
            LUI, AUIPC: begin
                nxt.kind        = K_ALU;
                nxt.alu_op      = (opcode == LUI) ? PASS_B : ADD;
                nxt.imm         = imm_u;
                nxt.src1_is_pc  = (opcode == AUIPC);
                nxt.src2_is_imm = 1'b1;
                nxt.rd_we       = 1'b1;
                use_rd          = 1'b1;
            end
            JAL: begin
                nxt.kind       = K_JUMP;
                nxt.imm        = imm_j;
                nxt.src1_is_pc = 1'b1;
                nxt.rd_we      = 1'b1;
                use_rd         = 1'b1;
            end
            JALR: begin
                if (funct3 == 3'b000) nxt.kind = K_JUMP;
                nxt.imm   = imm_i;
                nxt.rd_we = 1'b1;
                {use_rs1, use_rd} = 2'b11;
            end
            BRANCH: begin
                if (br_op_e'(funct3) inside {BEQ, BNE, BLT, BGE, BLTU, BGEU})
                    nxt.kind = K_BRANCH;
                nxt.imm = imm_b;
                {use_rs1, use_rs2} = 2'b11;
            end
            LOAD: begin
                if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) nxt.kind = K_LOAD;
                nxt.imm         = imm_i;
                nxt.src2_is_imm = 1'b1;
                {use_rs1, use_rd} = 2'b11;  // No data memory, so no write
            end
            STORE: begin
                if (funct3 inside {F3_B, F3_H, F3_W}) nxt.kind = K_STORE;
                nxt.imm         = imm_s;
                nxt.src2_is_imm = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
            end
            SYSTEM: begin
                nxt.imm = imm_i;
                if (funct3 == F3_PRIV) begin
                    if (rs1 == 5'd0 && rd == 5'd0) begin
                        if (funct12 == F12_EBREAK)
                            nxt.kind = K_EBREAK;
                        else if (funct12 == F12_ECALL || funct12 == F12_MRET)
                            nxt.kind = K_SYSTEM;
                    end
                end else if (funct3 != F3_CSR_RSVD) begin
                    nxt.kind = K_SYSTEM;  // CSR access, no CSR file behind it
                    use_rd   = 1'b1;
                    use_rs1  = ~funct3[2];
                end
            end
            default: ;
        endcase
        // RV32E style limit on register indexes
        if ((use_rs1 && rs1 >= gpr_count) || (use_rs2 && rs2 >= gpr_count) ||
            (use_rd && rd >= gpr_count))
            nxt.kind = K_ILLEGAL;
        if (nxt.kind == K_ILLEGAL) nxt.rd_we = 1'b0;
    end

    // ################################################
    // Handshake
    // ################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b0;
            case (state)
                IDLE: if (fetch_valid && fetch_ready) state <= BUSY;
                BUSY: if (exu_ready) begin
                    state     <= IDLE;
                    dec_valid <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_valid) begin
            pc_r   <= fetch.pc;
            inst_r <= fetch.inst;
        end
        if (state == BUSY && exu_ready) dec <= nxt;
    end

endmodule

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // ################################################
    // Major opcodes
    // ################################################
    typedef enum logic [6:0] {
        LOAD   = 7'h03,
        OP_IMM = 7'h13,
        AUIPC  = 7'h17,
        STORE  = 7'h23,
        OP     = 7'h33,
        LUI    = 7'h37,
        BRANCH = 7'h63,
        JALR   = 7'h67,
        JAL    = 7'h6f,
        SYSTEM = 7'h73
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
        PASS_B  // lui
    } alu_op_e;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_op_e;

    typedef enum logic [2:0] {
        K_ALU, K_BRANCH, K_JUMP, K_LOAD, K_STORE, K_SYSTEM, K_EBREAK, K_ILLEGAL
    } inst_kind_e;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // ################################################
    // Function codes
    // ################################################
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [2:0] F3_PRIV     = 3'b000;
    localparam logic [2:0] F3_CSR_RSVD = 3'b100;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;  // sub, sra, srai

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

endpackage

// File: sim.f
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/rv_gpr.sv
hw/rv_idu.sv
hw/rv_exu.sv
hw/rv_core_slice.sv
verif/core_slice_props.sv
verif/tb_core_slice.sv

// File: verif/core_slice_props.sv
`timescale 1ns/1ns

module core_slice_props (
    input logic        clk,
    input logic        rst,
    input logic        fetch_valid,
    input logic        fetch_ready,
    input logic        dec_valid,
    input logic        retire_valid,
    input logic        wr_en,
    input logic [4:0]  wr_addr,
    input logic [31:0] x0_value
);

    // One pulse per retired instruction
    no_double_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |=> !retire_valid)
        else $error("retire_valid high on two consecutive cycles");

    // ################################################
    // Fetch handshake
    // ################################################
    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && fetch_ready |=> !fetch_ready)
        else $error("fetch_ready still high after an accept");

    busy_until_issue: assert property (@(posedge clk) disable iff (rst)
        !fetch_ready |=> fetch_ready == dec_valid)  // Leaves BUSY only when issuing
        else $error("fetch_ready changed without dec_valid");

    // A write naming x0 leaves its storage at zero
    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        wr_en && wr_addr == 5'd0 |=> x0_value == '0)
        else $error("write to x0 changed its stored value");

    quiet_in_reset: assert property (@(posedge clk) rst |-> !retire_valid)
        else $error("retire_valid high during reset");

endmodule

bind rv_core_slice core_slice_props props (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .dec_valid    (dec_valid),
    .retire_valid (retire_valid),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .x0_value     (u_gpr.regs[0])
);

// File: verif/tb_core_slice.sv
`timescale 1ns/1ns

module tb_core_slice;

    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    localparam int gpr_count  = 32;
    localparam int per_test   = 50;
    localparam int max_cycles = 16 + 100 + 5 * per_test * 40;  // 40 cycles per instruction

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] imm;
        inst_kind_e  kind;
    } pend_t;

    logic        clk;
    logic        rst;
    fetch_t      fetch;
    logic        fetch_valid;
    logic        fetch_ready;
    retire_t     retire;
    logic        retire_valid;

    integer      seed = 34;
    int          errors = 0;
    int          retired = 0;
    int          failed_tests = 0;
    logic [31:0] pc_next = 32'h0000_1000;
    logic [31:0] regs [32];   // Model register file
    pend_t       pending [$];  // Accepted, not yet retired

    rv_core_slice #(.gpr_count(gpr_count)) dut (
        .clk          (clk),
        .rst          (rst),
        .fetch        (fetch),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(max_cycles * 100);
        $display("timeout after %0d cycles, not every instruction retired", max_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    // ################################################
    // Instruction encoding
    // ################################################
    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic make_inst(input int sel, output logic [31:0] inst, output logic [31:0] imm,
        output inst_kind_e kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] r;
        rd   = pick(gpr_count);
        rs1  = pick(gpr_count);
        rs2  = (pick(4) == 0) ? rs1 : pick(gpr_count);  // Equal operands for beq/bge
        r    = $random(seed);
        f3   = r[2:0];
        kind = K_ALU;
        imm  = '0;
        case (sel)
            2: begin
                if (f3 == F3_SLL || f3 == F3_SRL_SRA) f3 = F3_ADD_SUB;
                f7 = (f3 == F3_ADD_SUB && r[3]) ? F7_ALT : F7_BASE;
                case (pick(4))
                    0:       inst = r_type(f7, rs2, rs1, f3, rd, OP);
                    1: begin
                        imm  = {{20{r[31]}}, r[31:20]};
                        inst = i_type(imm[11:0], rs1, f3, rd, OP_IMM);
                    end
                    2: begin
                        imm  = {r[31:12], 12'b0};
                        inst = {r[31:12], rd, LUI};
                    end
                    default: begin
                        imm  = {r[31:12], 12'b0};
                        inst = {r[31:12], rd, AUIPC};
                    end
                endcase
            end
            3: begin
                f3 = r[1] ? F3_SRL_SRA : F3_SLL;
                f7 = (f3 == F3_SRL_SRA && r[2]) ? F7_ALT : F7_BASE;
                if (r[3]) begin
                    inst = r_type(f7, rs2, rs1, f3, rd, OP);
                end else begin
                    imm  = {20'b0, f7, r[24:20]};
                    inst = i_type(imm[11:0], rs1, f3, rd, OP_IMM);
                end
            end
            4: begin
                kind = K_JUMP;
                case (pick(4))
                    0: begin
                        imm  = {{11{r[31]}}, r[31:12], 1'b0};
                        inst = j_type(imm[20:0], rd);
                    end
                    1: begin
                        imm  = {{20{r[31]}}, r[31:20]};
                        inst = i_type(imm[11:0], rs1, 3'b000, rd, JALR);
                    end
                    default: begin
                        kind = K_BRANCH;
                        if (f3[2:1] == 2'b01) f3 = BEQ;
                        imm  = {{19{r[31]}}, r[31:20], 1'b0};
                        inst = b_type(imm[12:0], rs2, rs1, f3);
                    end
                endcase
            end
            5: begin
                kind = r[3] ? K_LOAD : K_STORE;
                if (f3 inside {3'b011, 3'b110, 3'b111} || (!r[3] && f3[2])) f3 = F3_W;
                imm  = {{20{r[31]}}, r[31:20]};
                if (r[3])
                    inst = i_type(imm[11:0], rs1, f3, rd, LOAD);
                else
                    inst = s_type(imm[11:0], rs2, rs1, f3);
            end
            default: case (pick(5))
                0: begin
                    kind = K_EBREAK;
                    inst = 32'h0010_0073;
                end
                1: begin
                    kind = K_SYSTEM;
                    inst = r[4] ? 32'h0000_0073 : 32'h3020_0073;  // ecall or mret
                end
                2: begin
                    kind = K_SYSTEM;
                    if (f3 == F3_PRIV || f3 == F3_CSR_RSVD) f3 = 3'b010;
                    inst = i_type(r[31:20], rs1, f3, rd, SYSTEM);
                end
                3: begin
                    kind = K_ILLEGAL;
                    inst = {r[31:7], 7'h0b};  // custom-0
                end
                default: begin
                    kind = K_ILLEGAL;
                    if (gpr_count < 32) rd = gpr_count + pick(32 - gpr_count);
                    inst = r_type((gpr_count < 32) ? F7_BASE : 7'h01, rs2, rs1, 3'b000, rd, OP);
                end
            endcase
        endcase
    endtask

    // ################################################
    // Reference model
    // ################################################
    function automatic logic [31:0] alu_result(input logic [31:0] inst, input logic [31:0] pc,
        input logic [31:0] imm, input logic [31:0] a, input logic [31:0] rb);
        logic [31:0] b;
        logic        is_op;
        is_op = (inst[6:0] == OP);
        b     = is_op ? rb : imm;
        if (inst[6:0] == LUI) return imm;
        if (inst[6:0] == AUIPC) return pc + imm;
        case (inst[14:12])
            3'b000: return (is_op && inst[30]) ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (inst[30]) return $signed(a) >>> b[4:0];
                else return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic report_mismatch(input string field, input logic [31:0] got,
        input logic [31:0] want);
        errors++;
        $display("mismatch at %0t ns: pc %h %s got %h, expected %h",
                 $time, retire.pc, field, got, want);
    endtask

    task automatic check_retire(input pend_t p);
        retire_t     exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] inst;
        inst = p.inst;
        a    = regs[inst[19:15]];
        b    = regs[inst[24:20]];
        exp  = '0;
        exp.next_pc  = p.pc + 32'd4;
        exp.rd_we    = (p.kind == K_ALU || p.kind == K_JUMP);
        exp.mem_size = (inst[13:12] == 2'b00) ? BYTE : (inst[13:12] == 2'b01) ? HALF : WORD;
        case (p.kind)
            K_ALU: exp.result = alu_result(inst, p.pc, p.imm, a, b);
            K_BRANCH: if (branch_taken(inst[14:12], a, b))
                exp.next_pc = p.pc + p.imm;
            K_JUMP: begin
                exp.result = p.pc + 32'd4;  // Link
                if (inst[6:0] == JAL)
                    exp.next_pc = p.pc + p.imm;
                else
                    exp.next_pc = (a + p.imm) & ~32'd1;
            end
            K_LOAD: exp.mem_addr = a + p.imm;
            K_STORE: begin
                exp.mem_addr   = a + p.imm;
                exp.store_data = b;
            end
            default: ;
        endcase
        retired++;
        assert (retire.pc === p.pc) else report_mismatch("pc", retire.pc, p.pc);
        assert (retire.kind === p.kind) else report_mismatch("kind", retire.kind, p.kind);
        assert (retire.rd_we === exp.rd_we) else report_mismatch("rd_we", retire.rd_we, exp.rd_we);
        assert (retire.next_pc === exp.next_pc)
            else report_mismatch("next_pc", retire.next_pc, exp.next_pc);
        if (exp.rd_we) begin
            assert (retire.rd === inst[11:7]) else report_mismatch("rd", retire.rd, inst[11:7]);
            assert (retire.result === exp.result)
                else report_mismatch("result", retire.result, exp.result);
            if (inst[11:7] != 5'd0) regs[inst[11:7]] = exp.result;
        end
        if (p.kind inside {K_LOAD, K_STORE}) begin
            assert (retire.mem_addr === exp.mem_addr)
                else report_mismatch("mem_addr", retire.mem_addr, exp.mem_addr);
            assert (retire.mem_size === exp.mem_size)
                else report_mismatch("mem_size", retire.mem_size, exp.mem_size);
        end
        if (p.kind == K_STORE)
            assert (retire.store_data === exp.store_data)
                else report_mismatch("store_data", retire.store_data, exp.store_data);
    endtask

    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            assert (pending.size() != 0) else begin
                errors++;
                $display("retire at %0t ns with no instruction outstanding", $time);
            end
            if (pending.size() != 0) check_retire(pending.pop_front());
        end
    end

    // ################################################
    // Stimulus
    // ################################################
    task automatic offer(input logic [31:0] inst, input logic [31:0] imm,
        input inst_kind_e kind, input int gap);
        pend_t p;
        fetch_valid = 1'b0;
        repeat (gap) @(negedge clk);
        p.pc        = pc_next;
        p.inst      = inst;
        p.imm       = imm;
        p.kind      = kind;
        fetch.pc    = pc_next;
        fetch.inst  = inst;
        fetch_valid = 1'b1;
        while (!fetch_ready) @(negedge clk);
        pending.push_back(p);  // Accepted at the coming rising edge
        pc_next += 32'd4;
        @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err0);
        if (errors != err0) failed_tests++;
        $display("test %s: %s", name, (errors == err0) ? "ok" : "errors found");
    endtask

    task automatic run_test(input string name, input int sel);
        logic [31:0] inst;
        logic [31:0] imm;
        inst_kind_e  kind;
        int          err0;
        err0 = errors;
        for (int i = 0; i < per_test; i++) begin
            make_inst(sel, inst, imm, kind);
            offer(inst, imm, kind, (sel == 3) ? 0 : pick(4));  // Shifts see a busy fetch side
        end
        fetch_valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        end_test(name, err0);
    endtask

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        foreach (regs[i]) regs[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (fetch_ready === 1'b1) else report_mismatch("fetch_ready", fetch_ready, 1);
            assert (retire_valid === 1'b0) else report_mismatch("retire_valid", retire_valid, 0);
        end
        end_test("reset", 0);
        run_test("alu", 2);
        run_test("shift", 3);
        run_test("branch_jump", 4);
        run_test("load_store", 5);
        run_test("system", 6);
        $display("6 tests, %0d failed, %0d instructions retired, %0d errors",
                 failed_tests, retired, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
